// File: hw/ptw_pkg.sv
// Sv39 single-stage only; widths fixed for a 56-bit physical and 39-bit virtual space

package ptw_pkg;

    // ----------------------------------------
    // Sv39 geometry
    // ----------------------------------------
    localparam int VLEN          = 39;
    localparam int PLEN          = 56;
    localparam int PPNW          = 44;
    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_SEG_W     = 9;
    // an entry is 8 bytes
    localparam int PTE_ADDR_LSB  = 3;
    localparam int ASID_W        = 16;
    localparam int VPN_W         = 27;

    // ----------------------------------------
    // page-table entry and transfer structs
    // ----------------------------------------
    typedef struct packed {
        logic [9:0]      reserved;
        logic [PPNW-1:0] ppn;
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // one miss handed from the arbiter to the walk engine
    typedef struct packed {
        logic              valid;
        logic              is_instr;
        logic [VLEN-1:0]   vaddr;
        logic [PPNW-1:0]   root_ppn;
        logic [ASID_W-1:0] asid;
        logic [PLEN-1:0]   pte_addr;
    } walk_req_t;

    typedef struct packed {
        logic              valid;
        logic              is_1g;
        logic              is_2m;
        logic [VPN_W-1:0]  vpn;
        logic [ASID_W-1:0] asid;
        pte_t              content;
    } tlb_update_t;

    // read-only memory port, always 64-bit reads
    typedef struct packed {
        logic            req;
        logic [PLEN-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [63:0] rdata;
    } mem_rsp_t;

    // ----------------------------------------
    // state and verdict encodings
    // ----------------------------------------
    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } ptw_state_e;

    // LVL1 maps 1 GiB, LVL2 2 MiB, LVL3 4 KiB
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_level_e;

    typedef enum logic [1:0] {
        PTE_POINTER,
        PTE_LEAF_OK,
        PTE_FAULT
    } pte_verdict_e;

endpackage

// File: hw/ptw_miss_arbiter.sv
// DTLB has priority; a request only leaves while the walker is idle and is not held if dropped

`timescale 1ns/1ns

module ptw_miss_arbiter import ptw_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    // instruction TLB
    input  logic              itlb_access_i,
    input  logic              itlb_hit_i,
    input  logic [VLEN-1:0]   itlb_vaddr_i,
    // data TLB
    input  logic              dtlb_access_i,
    input  logic              dtlb_hit_i,
    input  logic [VLEN-1:0]   dtlb_vaddr_i,
    // CSR state
    input  logic              enable_translation_i,
    input  logic              en_ld_st_translation_i,
    input  logic [PPNW-1:0]   satp_ppn_i,
    input  logic [ASID_W-1:0] asid_i,
    input  logic              walker_idle_i,
    output walk_req_t         walk_req_o,
    // performance counter strobes
    output logic              itlb_miss_o,
    output logic              dtlb_miss_o
);

    logic            itlb_sel;
    logic            dtlb_sel;
    logic [VLEN-1:0] sel_vaddr;

    // ITLB only gets through when the DTLB is quiet this cycle
    assign itlb_sel = walker_idle_i & enable_translation_i & itlb_access_i
                      & ~itlb_hit_i & ~dtlb_access_i;
    assign dtlb_sel = walker_idle_i & en_ld_st_translation_i & dtlb_access_i
                      & ~dtlb_hit_i;

    assign sel_vaddr = dtlb_sel ? dtlb_vaddr_i : itlb_vaddr_i;

    // ----------------------------------------
    // request build
    // ----------------------------------------
    always_comb begin
        walk_req_o.valid    = itlb_sel | dtlb_sel;
        walk_req_o.is_instr = itlb_sel;
        walk_req_o.vaddr    = sel_vaddr;
        walk_req_o.root_ppn = satp_ppn_i;
        walk_req_o.asid     = asid_i;
        // root table base plus VPN[2] scaled by the entry size
        walk_req_o.pte_addr = {satp_ppn_i,
                               sel_vaddr[VLEN-1:VLEN-VPN_SEG_W],
                               {PTE_ADDR_LSB{1'b0}}};
    end

    assign itlb_miss_o = itlb_sel;
    assign dtlb_miss_o = dtlb_sel;

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_one_miss_at_a_time : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(itlb_miss_o && dtlb_miss_o)
    ) else $error("both TLB miss strobes high in one cycle");

endmodule

// File: hw/ptw_pte_check.sv
// purely combinational PTE classifier; A and D are software managed, so missing bits fault

`timescale 1ns/1ns

module ptw_pte_check import ptw_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  pte_t         pte_i,
    input  ptw_level_e   level_i,
    input  logic         is_instr_i,
    input  logic         is_store_i,
    input  logic         mxr_i,
    output pte_verdict_e verdict_o
);

    logic is_leaf;
    logic invalid;
    logic bad_pointer;
    logic instr_fault;
    logic data_fault;
    logic store_fault;
    logic misaligned;
    logic leaf_fault;

    // r or x marks a leaf, otherwise the entry points one level down
    assign is_leaf = pte_i.r | pte_i.x;

    // ----------------------------------------
    // basic validity
    // ----------------------------------------
    // write-only pages are reserved encodings
    assign invalid = ~pte_i.v | (pte_i.w & ~pte_i.r);

    // no level below 4 KiB to point at
    assign bad_pointer = ~is_leaf & (level_i == LVL3);

    // ----------------------------------------
    // leaf permissions
    // ----------------------------------------
    assign instr_fault = is_instr_i & ~pte_i.x;

    // loads may read execute-only pages when MXR is set
    assign data_fault = ~is_instr_i & ~(pte_i.r | (pte_i.x & mxr_i));

    assign store_fault = ~is_instr_i & is_store_i & ~(pte_i.w & pte_i.d);

    // superpages need the low PPN slices clear
    always_comb begin
        case (level_i)
            LVL1:    misaligned = |pte_i.ppn[2*VPN_SEG_W-1:0];
            LVL2:    misaligned = |pte_i.ppn[VPN_SEG_W-1:0];
            default: misaligned = 1'b0;
        endcase
    end

    assign leaf_fault = is_leaf & (~pte_i.a | instr_fault | data_fault
                                   | store_fault | misaligned);

    // ----------------------------------------
    // verdict
    // ----------------------------------------
    always_comb begin
        if (invalid || bad_pointer || leaf_fault) begin
            verdict_o = PTE_FAULT;
        end else if (is_leaf) begin
            verdict_o = PTE_LEAF_OK;
        end else begin
            verdict_o = PTE_POINTER;
        end
    end

    // the walker acts on the verdict every lookup, so its registered
    // entry and level must stay defined from reset onward
    a_verdict_known : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(verdict_o)
    ) else $error("PTE verdict is unknown");

endmodule

// File: hw/ptw_walk_fsm.sv
// one walk at a time; read data is registered before use and a flush waits out an open read

`timescale 1ns/1ns

module ptw_walk_fsm import ptw_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  walk_req_t    walk_req_i,
    input  mem_rsp_t     mem_rsp_i,
    input  pte_verdict_e verdict_i,
    output mem_req_t     mem_req_o,
    output pte_t         pte_o,
    output ptw_level_e   level_o,
    output logic         is_instr_o,
    output logic         walker_idle_o,
    output logic         ptw_active_o,
    output logic         ptw_error_o,
    output tlb_update_t  itlb_update_o,
    output tlb_update_t  dtlb_update_o
);

    ptw_state_e        state_q, state_d;
    ptw_level_e        lvl_q, lvl_d;
    logic [PLEN-1:0]   pptr_q, pptr_d;
    logic [VLEN-1:0]   vaddr_q, vaddr_d;
    logic [ASID_W-1:0] asid_q, asid_d;
    logic              is_instr_q, is_instr_d;
    logic              global_q, global_d;

    // registered memory response
    logic              rvalid_q;
    pte_t              pte_q;

    logic [VPN_SEG_W-1:0] next_slice;
    logic                 leaf_hit;
    tlb_update_t          update;

    assign pte_o         = pte_q;
    assign level_o       = lvl_q;
    assign is_instr_o    = is_instr_q;
    assign walker_idle_o = (state_q == IDLE);
    assign ptw_active_o  = (state_q != IDLE);

    assign mem_req_o.req  = (state_q == WAIT_GRANT);
    assign mem_req_o.addr = pptr_q;

    // VPN[1] after the root, VPN[0] after the middle table
    assign next_slice = (lvl_q == LVL1) ? vaddr_q[VLEN-VPN_SEG_W-1:VLEN-2*VPN_SEG_W]
                                        : vaddr_q[PAGE_OFFSET_W+VPN_SEG_W-1:PAGE_OFFSET_W];

    assign leaf_hit = (state_q == PTE_LOOKUP) && rvalid_q && (verdict_i == PTE_LEAF_OK)
                      && !flush_i;

    // ----------------------------------------
    // TLB update
    // ----------------------------------------
    always_comb begin
        update.valid     = 1'b0;
        update.is_1g     = (lvl_q == LVL1);
        update.is_2m     = (lvl_q == LVL2);
        update.vpn       = vaddr_q[VLEN-1:PAGE_OFFSET_W];
        update.asid      = asid_q;
        update.content   = pte_q;
        // global if any entry on the way down was global
        update.content.g = pte_q.g | global_q;

        itlb_update_o       = update;
        dtlb_update_o       = update;
        itlb_update_o.valid = leaf_hit & is_instr_q;
        dtlb_update_o.valid = leaf_hit & ~is_instr_q;
    end

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        state_d     = state_q;
        lvl_d       = lvl_q;
        pptr_d      = pptr_q;
        vaddr_d     = vaddr_q;
        asid_d      = asid_q;
        is_instr_d  = is_instr_q;
        global_d    = global_q;
        ptw_error_o = 1'b0;

        case (state_q)
            IDLE: begin
                lvl_d    = LVL1;
                global_d = 1'b0;
                if (walk_req_i.valid) begin
                    pptr_d     = walk_req_i.pte_addr;
                    vaddr_d    = walk_req_i.vaddr;
                    asid_d     = walk_req_i.asid;
                    is_instr_d = walk_req_i.is_instr;
                    state_d    = WAIT_GRANT;
                end
            end

            WAIT_GRANT: begin
                if (mem_rsp_i.gnt) begin
                    state_d = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                if (rvalid_q) begin
                    if (pte_q.g) begin
                        global_d = 1'b1;
                    end
                    case (verdict_i)
                        PTE_POINTER: begin
                            lvl_d   = (lvl_q == LVL1) ? LVL2 : LVL3;
                            pptr_d  = {pte_q.ppn, next_slice, {PTE_ADDR_LSB{1'b0}}};
                            state_d = WAIT_GRANT;
                        end
                        PTE_LEAF_OK: state_d = IDLE;
                        default:     state_d = PROPAGATE_ERROR;
                    endcase
                end
            end

            PROPAGATE_ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = IDLE;
            end

            // a flushed read still has to come back before a new walk
            WAIT_RVALID: begin
                if (rvalid_q) begin
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase

        // flush wins over everything above
        if (flush_i) begin
            if ((state_q == WAIT_GRANT && mem_rsp_i.gnt) ||
                (state_q == PTE_LOOKUP && !rvalid_q)) begin
                state_d = WAIT_RVALID;
            end else begin
                state_d = IDLE;
            end
        end
    end

    // ----------------------------------------
    // registers
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            lvl_q      <= LVL1;
            is_instr_q <= 1'b0;
            global_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            pte_q      <= '0;
        end else begin
            state_q    <= state_d;
            lvl_q      <= lvl_d;
            is_instr_q <= is_instr_d;
            global_q   <= global_d;
            rvalid_q   <= mem_rsp_i.rvalid;
            if (mem_rsp_i.rvalid) begin
                pte_q <= pte_t'(mem_rsp_i.rdata);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        pptr_q  <= pptr_d;
        vaddr_q <= vaddr_d;
        asid_q  <= asid_d;
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // an ungranted request is held in WAIT_GRANT unless flushed
    a_req_held : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.req && !mem_rsp_i.gnt && !flush_i |=>
            mem_req_o.req && (state_q == WAIT_GRANT) && $stable(mem_req_o.addr)
    ) else $error("memory request dropped before grant");

endmodule

// File: hw/ptw_top.sv
// Sv39 walker top; no PMP check on table reads and no write-back of A or D bits

`timescale 1ns/1ns

module ptw_top import ptw_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    // TLB miss ports
    input  logic              itlb_access_i,
    input  logic              itlb_hit_i,
    input  logic [VLEN-1:0]   itlb_vaddr_i,
    input  logic              dtlb_access_i,
    input  logic              dtlb_hit_i,
    input  logic [VLEN-1:0]   dtlb_vaddr_i,
    // CSR and LSU state
    input  logic              enable_translation_i,
    input  logic              en_ld_st_translation_i,
    input  logic [PPNW-1:0]   satp_ppn_i,
    input  logic [ASID_W-1:0] asid_i,
    input  logic              mxr_i,
    input  logic              lsu_is_store_i,
    // memory port
    output mem_req_t          mem_req_o,
    input  mem_rsp_t          mem_rsp_i,
    // results
    output tlb_update_t       itlb_update_o,
    output tlb_update_t       dtlb_update_o,
    output logic              ptw_active_o,
    output logic              ptw_error_o,
    output logic              itlb_miss_o,
    output logic              dtlb_miss_o
);

    walk_req_t    walk_req;
    logic         walker_idle;
    pte_t         pte;
    ptw_level_e   level;
    logic         is_instr;
    pte_verdict_e verdict;

    ptw_miss_arbiter u_arbiter (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .itlb_access_i          (itlb_access_i),
        .itlb_hit_i             (itlb_hit_i),
        .itlb_vaddr_i           (itlb_vaddr_i),
        .dtlb_access_i          (dtlb_access_i),
        .dtlb_hit_i             (dtlb_hit_i),
        .dtlb_vaddr_i           (dtlb_vaddr_i),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .satp_ppn_i             (satp_ppn_i),
        .asid_i                 (asid_i),
        .walker_idle_i          (walker_idle),
        .walk_req_o             (walk_req),
        .itlb_miss_o            (itlb_miss_o),
        .dtlb_miss_o            (dtlb_miss_o)
    );

    ptw_walk_fsm u_walk (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .walk_req_i    (walk_req),
        .mem_rsp_i     (mem_rsp_i),
        .verdict_i     (verdict),
        .mem_req_o     (mem_req_o),
        .pte_o         (pte),
        .level_o       (level),
        .is_instr_o    (is_instr),
        .walker_idle_o (walker_idle),
        .ptw_active_o  (ptw_active_o),
        .ptw_error_o   (ptw_error_o),
        .itlb_update_o (itlb_update_o),
        .dtlb_update_o (dtlb_update_o)
    );

    ptw_pte_check u_pte_check (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .pte_i      (pte),
        .level_i    (level),
        .is_instr_i (is_instr),
        .is_store_i (lsu_is_store_i),
        .mxr_i      (mxr_i),
        .verdict_o  (verdict)
    );

endmodule

// File: testbench/tb_ptw_top.sv
// directed tests only; the memory model answers every read and unmapped entries read as zero

`timescale 1ns/1ns

module tb_ptw_top import ptw_pkg::*; ();

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              itlb_access;
    logic              itlb_hit;
    logic [VLEN-1:0]   itlb_vaddr;
    logic              dtlb_access;
    logic              dtlb_hit;
    logic [VLEN-1:0]   dtlb_vaddr;
    logic              en_trans;
    logic              en_ld_st;
    logic [PPNW-1:0]   satp_ppn;
    logic [ASID_W-1:0] asid;
    logic              mxr;
    logic              is_store;
    mem_req_t          mem_req;
    mem_rsp_t          mem_rsp;
    tlb_update_t       itlb_update;
    tlb_update_t       dtlb_update;
    logic              ptw_active;
    logic              ptw_error;
    logic              itlb_miss;
    logic              dtlb_miss;

    // page-table memory, keyed by byte address of the entry
    logic [63:0]     mem [logic [PLEN-1:0]];
    logic [PLEN-1:0] reads [$];
    logic [1:0]      wait_cnt;
    integer          seed = 32'hdcfa_d707;
    logic [PPNW-1:0] root_ppn;

    // event counters kept by the monitor
    int          upd_i_cnt = 0;
    int          upd_d_cnt = 0;
    int          err_cnt = 0;
    int          miss_i_cnt = 0;
    int          miss_d_cnt = 0;
    tlb_update_t last_upd;

    // values at the start of the current walk
    int upd_i_base;
    int upd_d_base;
    int err_base;
    int miss_i_base;
    int miss_d_base;
    int rd_base;

    int cycle_cnt = 0;

    ptw_top dut0 (
        .clk_i                  (clk),
        .rst_ni                 (rst_n),
        .flush_i                (flush),
        .itlb_access_i          (itlb_access),
        .itlb_hit_i             (itlb_hit),
        .itlb_vaddr_i           (itlb_vaddr),
        .dtlb_access_i          (dtlb_access),
        .dtlb_hit_i             (dtlb_hit),
        .dtlb_vaddr_i           (dtlb_vaddr),
        .enable_translation_i   (en_trans),
        .en_ld_st_translation_i (en_ld_st),
        .satp_ppn_i             (satp_ppn),
        .asid_i                 (asid),
        .mxr_i                  (mxr),
        .lsu_is_store_i         (is_store),
        .mem_req_o              (mem_req),
        .mem_rsp_i              (mem_rsp),
        .itlb_update_o          (itlb_update),
        .dtlb_update_o          (dtlb_update),
        .ptw_active_o           (ptw_active),
        .ptw_error_o            (ptw_error),
        .itlb_miss_o            (itlb_miss),
        .dtlb_miss_o            (dtlb_miss)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // memory model and monitor
    // ----------------------------------------
    // grant after 0 to 2 idle cycles, read data one cycle after the grant
    initial begin : mem_model
        logic            req_seen;
        logic            gnt_seen;
        logic [PLEN-1:0] addr;
        mem_rsp  = '0;
        wait_cnt = 2'd0;
        forever begin
            @(negedge clk);
            req_seen = mem_req.req;
            gnt_seen = mem_rsp.gnt;
            addr     = mem_req.addr;
            @(posedge clk);
            if (req_seen && gnt_seen) begin
                reads.push_back(addr);
                mem_rsp.gnt    <= 1'b0;
                mem_rsp.rvalid <= 1'b1;
                mem_rsp.rdata  <= mem.exists(addr) ? mem[addr] : 64'h0;
                wait_cnt = 2'($unsigned($random(seed)) % 3);
            end else begin
                mem_rsp.rvalid <= 1'b0;
                if (!req_seen) begin
                    mem_rsp.gnt <= 1'b0;
                    wait_cnt = 2'($unsigned($random(seed)) % 3);
                end else if (wait_cnt == 2'd0) begin
                    mem_rsp.gnt <= 1'b1;
                end else begin
                    wait_cnt = wait_cnt - 2'd1;
                end
            end
        end
    end

    initial begin : monitor
        forever begin
            @(negedge clk);
            if (itlb_update.valid) begin
                upd_i_cnt = upd_i_cnt + 1;
                last_upd  = itlb_update;
            end
            if (dtlb_update.valid) begin
                upd_d_cnt = upd_d_cnt + 1;
                last_upd  = dtlb_update;
            end
            err_cnt    = err_cnt + (ptw_error ? 1 : 0);
            miss_i_cnt = miss_i_cnt + (itlb_miss ? 1 : 0);
            miss_d_cnt = miss_d_cnt + (dtlb_miss ? 1 : 0);
        end
    end

    // longest walk is well under 30 cycles and there are about 20 of them
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= 4000) begin
            $display("timeout: the tests did not finish within 4000 clock cycles");
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // flag byte is d a g u x w r v from bit 7 down
    function automatic logic [63:0] make_pte(input logic [PPNW-1:0] ppn, input logic [7:0] flags);
        make_pte = {10'h000, ppn, 2'b00, flags};
    endfunction

    // table base is the ppn times the page size, each entry takes 8 bytes
    function automatic logic [PLEN-1:0] ent_addr(input logic [PPNW-1:0] ppn,
                                                 input logic [8:0] idx);
        ent_addr = (PLEN'(ppn) << PAGE_OFFSET_W) + PLEN'(idx) * 8;
    endfunction

    // three-level path through tables at 0x80001 and 0x80002
    task automatic map_4k(input logic [VLEN-1:0] va, input logic [7:0] top_flags,
                          input logic [63:0] leaf);
        mem[ent_addr(root_ppn, va[38:30])]  = make_pte(44'h8_0001, top_flags);
        mem[ent_addr(44'h8_0001, va[29:21])] = make_pte(44'h8_0002, 8'b0000_0001);
        mem[ent_addr(44'h8_0002, va[20:12])] = leaf;
    endtask

    task automatic snapshot();
        upd_i_base  = upd_i_cnt;
        upd_d_base  = upd_d_cnt;
        err_base    = err_cnt;
        miss_i_base = miss_i_cnt;
        miss_d_base = miss_d_cnt;
        rd_base     = reads.size();
    endtask

    // one-cycle access on both TLB ports
    task automatic drive_miss(input logic i_acc, input logic i_hit, input logic [VLEN-1:0] i_va,
                              input logic d_acc, input logic d_hit, input logic [VLEN-1:0] d_va);
        @(posedge clk);
        itlb_access <= i_acc;
        itlb_hit    <= i_hit;
        itlb_vaddr  <= i_va;
        dtlb_access <= d_acc;
        dtlb_hit    <= d_hit;
        dtlb_vaddr  <= d_va;
        @(posedge clk);
        itlb_access <= 1'b0;
        itlb_hit    <= 1'b0;
        dtlb_access <= 1'b0;
        dtlb_hit    <= 1'b0;
    endtask

    task automatic start_walk(input logic instr, input logic [VLEN-1:0] va);
        snapshot();
        drive_miss(instr, 1'b0, va, !instr, 1'b0, va);
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (ptw_active);
    endtask

    task automatic check_counts(input int i_upd, input int d_upd, input int errs,
                                input int nreads);
        check("itlb_update_o.valid pulses", 64'(upd_i_cnt - upd_i_base), 64'(i_upd));
        check("dtlb_update_o.valid pulses", 64'(upd_d_cnt - upd_d_base), 64'(d_upd));
        check("ptw_error_o pulses", 64'(err_cnt - err_base), 64'(errs));
        check("mem_req_o reads", 64'(reads.size() - rd_base), 64'(nreads));
    endtask

    // 4 KiB data or instruction walk that ends in an update or a fault
    task automatic walk_case(input logic instr, input logic store, input logic mx,
                             input logic [7:0] flags, input logic ok);
        logic [VLEN-1:0] va;
        int              exp_i;
        int              exp_d;
        va    = {9'h155, 9'h0aa, 9'h033, 12'h000};
        exp_i = (ok && instr) ? 1 : 0;
        exp_d = (ok && !instr) ? 1 : 0;
        mem.delete();
        map_4k(va, 8'b0000_0001, make_pte(44'h1_2345, flags));
        @(posedge clk);
        is_store <= store;
        mxr      <= mx;
        start_walk(instr, va);
        wait_done();
        check_counts(exp_i, exp_d, ok ? 0 : 1, 3);
    endtask

    task automatic expect_quiet();
        repeat (4) begin
            @(negedge clk);
            check("ptw_active_o", 64'(ptw_active), 64'd0);
        end
        check("itlb_miss_o pulses", 64'(miss_i_cnt - miss_i_base), 64'd0);
        check("dtlb_miss_o pulses", 64'(miss_d_cnt - miss_d_base), 64'd0);
        check("mem_req_o reads", 64'(reads.size() - rd_base), 64'd0);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic itlb_4k_walk();
        logic [VLEN-1:0] va;
        logic [63:0]     leaf;
        va   = {9'h1a3, 9'h05c, 9'h1ff, 12'h123};
        leaf = make_pte(44'h1_2345, 8'b1100_1011);
        mem.delete();
        // root pointer carries g, so the update must too
        map_4k(va, 8'b0010_0001, leaf);
        start_walk(1'b1, va);
        wait_done();
        check_counts(1, 0, 0, 3);
        check("read 0 addr", 64'(reads[rd_base]), 64'(ent_addr(root_ppn, va[38:30])));
        check("read 1 addr", 64'(reads[rd_base + 1]), 64'(ent_addr(44'h8_0001, va[29:21])));
        check("read 2 addr", 64'(reads[rd_base + 2]), 64'(ent_addr(44'h8_0002, va[20:12])));
        check("itlb_miss_o pulses", 64'(miss_i_cnt - miss_i_base), 64'd1);
        check("dtlb_miss_o pulses", 64'(miss_d_cnt - miss_d_base), 64'd0);
        check("itlb_update_o.vpn", 64'(last_upd.vpn), 64'(va[38:12]));
        check("itlb_update_o.is_1g", 64'(last_upd.is_1g), 64'd0);
        check("itlb_update_o.is_2m", 64'(last_upd.is_2m), 64'd0);
        check("itlb_update_o.asid", 64'(last_upd.asid), 64'h5a5a);
        check("itlb_update_o.content", 64'(last_upd.content), leaf | 64'h20);
    endtask

    task automatic dtlb_superpages();
        logic [VLEN-1:0] va;
        logic [63:0]     leaf;
        va = {9'h0c7, 9'h011, 9'h022, 12'h456};
        mem.delete();
        leaf = make_pte(44'h10_0000, 8'b1100_0111);
        mem[ent_addr(root_ppn, va[38:30])] = leaf;
        start_walk(1'b0, va);
        wait_done();
        check_counts(0, 1, 0, 1);
        check("dtlb_update_o.is_1g", 64'(last_upd.is_1g), 64'd1);
        check("dtlb_update_o.is_2m", 64'(last_upd.is_2m), 64'd0);
        check("dtlb_update_o.content", 64'(last_upd.content), leaf);
        check("dtlb_miss_o pulses", 64'(miss_d_cnt - miss_d_base), 64'd1);

        mem[ent_addr(root_ppn, va[38:30])] = make_pte(44'h8_0001, 8'b0000_0001);
        leaf = make_pte(44'h3_fe00, 8'b1100_0111);
        mem[ent_addr(44'h8_0001, va[29:21])] = leaf;
        start_walk(1'b0, va);
        wait_done();
        check_counts(0, 1, 0, 2);
        check("dtlb_update_o.is_1g", 64'(last_upd.is_1g), 64'd0);
        check("dtlb_update_o.is_2m", 64'(last_upd.is_2m), 64'd1);
        check("dtlb_update_o.content", 64'(last_upd.content), leaf);
        check("dtlb_update_o.vpn", 64'(last_upd.vpn), 64'(va[38:12]));

        // low PPN bit set on a 2 MiB leaf
        mem[ent_addr(44'h8_0001, va[29:21])] = make_pte(44'h3_fe01, 8'b1100_0111);
        start_walk(1'b0, va);
        wait_done();
        check_counts(0, 0, 1, 2);
    endtask

    task automatic permission_faults();
        walk_case(1'b0, 1'b0, 1'b0, 8'b1100_0110, 1'b0);
        walk_case(1'b0, 1'b0, 1'b0, 8'b1100_0101, 1'b0);
        walk_case(1'b1, 1'b0, 1'b0, 8'b1100_0011, 1'b0);
        walk_case(1'b0, 1'b1, 1'b0, 8'b0100_0111, 1'b0);
        walk_case(1'b0, 1'b0, 1'b0, 8'b1000_0011, 1'b0);
        // execute-only page read by a load
        walk_case(1'b0, 1'b0, 1'b0, 8'b1100_1001, 1'b0);
        walk_case(1'b0, 1'b0, 1'b1, 8'b1100_1001, 1'b1);
    endtask

    task automatic last_level_pointer();
        walk_case(1'b0, 1'b0, 1'b0, 8'b0000_0001, 1'b0);
    endtask

    task automatic miss_arbitration();
        logic [VLEN-1:0] va_i;
        logic [VLEN-1:0] va_d;
        va_i = {9'h011, 9'h022, 9'h033, 12'h000};
        va_d = {9'h0aa, 9'h0bb, 9'h0cc, 12'h000};
        mem.delete();
        map_4k(va_d, 8'b0000_0001, make_pte(44'h2222, 8'b1100_0111));
        snapshot();
        drive_miss(1'b1, 1'b0, va_i, 1'b1, 1'b0, va_d);
        wait_done();
        check_counts(0, 1, 0, 3);
        check("itlb_miss_o pulses", 64'(miss_i_cnt - miss_i_base), 64'd0);
        check("dtlb_miss_o pulses", 64'(miss_d_cnt - miss_d_base), 64'd1);
        check("read 0 addr", 64'(reads[rd_base]), 64'(ent_addr(root_ppn, va_d[38:30])));
        check("dtlb_update_o.vpn", 64'(last_upd.vpn), 64'(va_d[38:12]));

        // each port on its own, so the ITLB is not masked by a DTLB access
        snapshot();
        drive_miss(1'b1, 1'b1, va_i, 1'b0, 1'b0, va_d);
        drive_miss(1'b0, 1'b0, va_i, 1'b1, 1'b1, va_d);
        expect_quiet();

        @(posedge clk);
        en_trans <= 1'b0;
        en_ld_st <= 1'b0;
        snapshot();
        drive_miss(1'b1, 1'b0, va_i, 1'b0, 1'b0, va_d);
        drive_miss(1'b0, 1'b0, va_i, 1'b1, 1'b0, va_d);
        expect_quiet();
        @(posedge clk);
        en_trans <= 1'b1;
        en_ld_st <= 1'b1;
    endtask

    task automatic flush_mid_walk();
        logic [VLEN-1:0] va;
        va = {9'h1a3, 9'h05c, 9'h1ff, 12'h000};
        mem.delete();
        map_4k(va, 8'b0000_0001, make_pte(44'h1_2345, 8'b1100_1011));
        start_walk(1'b1, va);
        // flush in the cycle after the first grant, read still in flight
        do begin
            @(negedge clk);
        end while (!(mem_req.req && mem_rsp.gnt));
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check("ptw_active_o", 64'(ptw_active), 64'd1);
        wait_done();
        check_counts(0, 0, 0, 1);
        itlb_4k_walk();
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        root_ppn    = 44'h8_0000;
        rst_n       = 1'b0;
        flush       = 1'b0;
        itlb_access = 1'b0;
        itlb_hit    = 1'b0;
        itlb_vaddr  = '0;
        dtlb_access = 1'b0;
        dtlb_hit    = 1'b0;
        dtlb_vaddr  = '0;
        en_trans    = 1'b1;
        en_ld_st    = 1'b1;
        satp_ppn    = root_ppn;
        asid        = 16'h5a5a;
        mxr         = 1'b0;
        is_store    = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        itlb_4k_walk();
        dtlb_superpages();
        permission_faults();
        last_level_pointer();
        miss_arbitration();
        flush_mid_walk();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: ptw_top.f
hw/ptw_pkg.sv
hw/ptw_miss_arbiter.sv
hw/ptw_pte_check.sv
hw/ptw_walk_fsm.sv
hw/ptw_top.sv
testbench/tb_ptw_top.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the Sv39 walker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ptw_top -f ptw_top.f

sim_out=$(./obj_dir/Vtb_ptw_top) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
